// File: rtg_bus_pkg.sv
// Wishbone classic types for the frame-buffer fetch; 16-bit data, byte address 25 bits
`default_nettype none

package rtg_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Address and data widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [24:0] wb_addr_t;           // Byte address
  typedef logic [15:0] wb_data_t;           // One 16-bit bus word
  typedef logic [20:0] line_base_t;         // Byte address bits 24..4

  localparam int unsigned wb_word_bytes = 2; // Address step per word

  ////////////////////////////////////////////////////////////////////////////
  // Master request and slave response
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic     cyc;                          // Bus cycle open
    logic     stb;                          // Strobe, same as cyc here
    wb_addr_t adr;                          // Held until ack
  } wb_req_t;                               // 27 bits

  typedef struct packed {
    logic     ack;                          // Data valid this edge
    wb_data_t dat;
  } wb_rsp_t;                               // 17 bits

endpackage

`default_nettype wire

// File: rtg_video_pkg.sv
// Hi-colour video types only (no CLUT); chipset sync bits stay active low as delivered
`default_nettype none

package rtg_video_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Colour
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0] rgb_chan_t;           // One output channel

  typedef struct packed {
    rgb_chan_t r;
    rgb_chan_t g;
    rgb_chan_t b;
  } rgb_t;                                  // 24 bits, red on top

  typedef struct packed {
    logic       unused;                     // Bit 15, ignored
    logic [4:0] r;
    logic [4:0] g;
    logic [4:0] b;
  } hicolour_t;                             // Frame-buffer word, 5-5-5

  // 5-bit field to 8 bits, top bits repeated below
  function automatic rgb_chan_t expand5(input logic [4:0] f);
    return {f, f[4:2]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Timing, configuration and ports
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [2:0] pixel_width_t;        // Clocks per pixel minus one
  typedef logic [4:0] vb_lines_t;           // Lines of local vblank

  typedef struct packed {
    logic hs;                               // Active low
    logic vs;                               // Active low
    logic cs;                               // Active low
    logic hblank;
    logic vblank;
    rgb_t rgb;
  } chip_video_t;                           // 29 bits

  typedef struct packed {
    logic window;                           // OSD area
    logic pixel;                            // OSD foreground
  } osd_t;

  typedef struct packed {
    logic                    ena;           // Graphics card shown
    rtg_bus_pkg::line_base_t base;          // Frame start, 16-byte aligned
    pixel_width_t            pixel_width;
    vb_lines_t               vbend;
    logic                    ext;           // One extra fetch at blank start
  } rtg_cfg_t;                              // 31 bits

  typedef struct packed {
    logic cs;
    logic hs;
    logic vs;
    rgb_t rgb;
  } vga_t;                                  // 27 bits

  typedef struct packed {
    logic active;                           // Show card colour
    logic flush;                            // Restart frame fetch
    logic pop;                              // Pixel strobe
  } pix_ctl_t;

endpackage

`default_nettype wire

// File: rtg_fetch.sv
// One Wishbone read in flight; fifo_depth_log2 1..5; a word acked across a flush is dropped
`default_nettype none
`timescale 1ns/1ns

module rtg_fetch #(
  parameter int unsigned fifo_depth_log2 = 3 // FIFO holds 2**n words
) (
  input  logic                     CLK_114,
  input  logic                     arst_n,
  input  rtg_bus_pkg::line_base_t  cfg_base,
  input  rtg_video_pkg::pix_ctl_t  ctl,
  output rtg_bus_pkg::wb_req_t     wb_req,
  input  rtg_bus_pkg::wb_rsp_t     wb_rsp,
  output rtg_video_pkg::hicolour_t head
);

  import rtg_bus_pkg::*;

  localparam int unsigned fifo_depth = 1 << fifo_depth_log2;

  typedef logic [fifo_depth_log2-1:0] fifo_ptr_t;
  typedef logic [fifo_depth_log2:0]   fifo_cnt_t; // One more bit for full

  typedef enum logic {
    st_idle,                                // Bus quiet
    st_req                                  // cyc/stb high, waiting ack
  } fetch_state_t;

  fetch_state_t state;
  wb_addr_t     next_adr;                   // Unmangled, next word
  wb_addr_t     req_adr;                    // Mangled, on the bus
  logic         discard;                    // Flush hit the open cycle
  wb_data_t     fifo_mem [fifo_depth];
  fifo_ptr_t    wr_ptr;
  fifo_ptr_t    rd_ptr;
  fifo_cnt_t    fill;                       // Words held
  logic         room;
  logic         start;
  logic         push;
  logic         pull;

  // Same bit-23 swap as the CPU side applies
  function automatic wb_addr_t mangle(input wb_addr_t a);
    wb_addr_t m;
    m     = a;
    m[23] = a[23] ^ (a[22] | a[21]);
    return m;
  endfunction

  assign room  = (fill < fifo_cnt_t'(fifo_depth)); // Idle, so nothing in flight
  assign start = (state == st_idle) && room && !ctl.flush;
  assign push  = (state == st_req) && wb_rsp.ack && !discard && !ctl.flush;
  assign pull  = ctl.pop && (fill != '0);   // Pop on empty ignored

  ////////////////////////////////////////////////////////////////////////////
  // Bus FSM and address counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      next_adr <= '0;
      req_adr  <= '0;
      discard  <= 1'b0;
    end else begin
      unique case (state)
        st_idle: begin
          if (start) begin
            state   <= st_req;
            req_adr <= mangle(next_adr);    // Frozen until ack
          end
        end
        st_req: begin
          if (wb_rsp.ack) begin
            state <= st_idle;               // At least one quiet clock
          end
        end
      endcase

      if (ctl.flush) begin
        next_adr <= {cfg_base, 4'b0000};    // Reload frame base
      end else if (start) begin
        next_adr <= next_adr + wb_addr_t'(wb_word_bytes);
      end

      if (state == st_req && wb_rsp.ack) begin
        discard <= 1'b0;                    // Cycle done
      end else if (state == st_req && ctl.flush) begin
        discard <= 1'b1;                    // Let it finish, drop the word
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pixel-word FIFO
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114) begin
    if (push) begin
      fifo_mem[wr_ptr] <= wb_rsp.dat;       // Captured on the ack edge
    end
  end

  always_ff @(posedge CLK_114 or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else if (ctl.flush) begin
      wr_ptr <= '0;                         // Empty for the new frame
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pull) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill <= fill + fifo_cnt_t'(push) - fifo_cnt_t'(pull);
    end
  end

  assign head = fifo_mem[rd_ptr];           // Oldest word

  always_comb begin
    wb_req.cyc = (state == st_req);
    wb_req.stb = (state == st_req);
    wb_req.adr = req_adr;
  end

endmodule

`default_nettype wire

// File: rtg_pixel_timing.sv
// Local vblank counts rising edges of chipset hs as delivered; vbend of 0 means no extra lines
`default_nettype none
`timescale 1ns/1ns

module rtg_pixel_timing (
  input  logic                        CLK_114,
  input  logic                        arst_n,
  input  rtg_video_pkg::chip_video_t  chip,
  input  rtg_video_pkg::rtg_cfg_t     cfg,
  output rtg_video_pkg::pix_ctl_t     ctl
);

  import rtg_video_pkg::*;

  pixel_width_t pix_ctr;                    // Clocks into current pixel
  vb_lines_t    vb_ctr;                     // Lines since chipset vblank
  logic         loc_vblank;                 // Local vertical blank
  logic         blank;
  logic         blank_d;
  logic         blank_rise;                 // Blank began this clock
  logic         hs_d;
  logic         hs_rise;
  logic         pop;

  assign blank      = loc_vblank | chip.hblank;
  assign blank_rise = blank & ~blank_d;
  assign hs_rise    = chip.hs & ~hs_d;

  // Strobe on the last clock of each pixel, plus one at blank start with ext
  assign pop = cfg.ena && (!blank || (cfg.ext && blank_rise)) &&
               (pix_ctr == cfg.pixel_width);

  ////////////////////////////////////////////////////////////////////////////
  // Delayed copies and pixel counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114 or negedge arst_n) begin
    if (!arst_n) begin
      blank_d <= 1'b1;
      hs_d    <= 1'b1;                      // Sync idles high
      pix_ctr <= '0;
    end else begin
      blank_d <= blank;
      hs_d    <= chip.hs;
      if (blank || pop) begin
        pix_ctr <= '0;                      // Restart pixel
      end else begin
        pix_ctr <= pix_ctr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Local vertical blank
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114 or negedge arst_n) begin
    if (!arst_n) begin
      loc_vblank <= 1'b1;
      vb_ctr     <= '0;
    end else if (chip.vblank) begin
      loc_vblank <= 1'b1;                   // Held through chipset vblank
      vb_ctr     <= '0;
    end else if (vb_ctr == cfg.vbend) begin
      loc_vblank <= 1'b0;                   // Extra lines done
    end else if (hs_rise) begin
      vb_ctr <= vb_ctr + 1'b1;              // One more line
    end
  end

  always_comb begin
    ctl.active = cfg.ena & ~blank;
    ctl.flush  = ~cfg.ena | chip.vblank;    // Restart fetch for next frame
    ctl.pop    = pop;
  end

endmodule

`default_nettype wire

// File: rtg_colour_out.sv
// Output registered one clock after inputs; OSD overlay is combinational on that register
`default_nettype none
`timescale 1ns/1ns

module rtg_colour_out (
  input  logic                        CLK_114,
  input  logic                        arst_n,
  input  rtg_video_pkg::chip_video_t  chip,
  input  rtg_video_pkg::pix_ctl_t     ctl,
  input  rtg_video_pkg::hicolour_t    head,
  input  rtg_video_pkg::osd_t         osd,
  output rtg_video_pkg::vga_t         vga
);

  import rtg_video_pkg::*;

  rgb_t       card_rgb;                     // Expanded head word
  rgb_t       sel_rgb;                      // Card or chipset colour
  vga_t       vga_q;                        // Output register
  logic [1:0] osd_r_top;
  logic [1:0] osd_g_top;
  logic [1:0] osd_b_top;

  // OSD keeps the top six bits of the pixel underneath
  function automatic rgb_chan_t overlay(input rgb_chan_t chan, input logic [1:0] top);
    return {top, chan[7:2]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Colour select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    card_rgb.r = expand5(head.r);
    card_rgb.g = expand5(head.g);
    card_rgb.b = expand5(head.b);
  end

  assign sel_rgb = ctl.active ? card_rgb : chip.rgb; // Chipset in blank

  always_ff @(posedge CLK_114 or negedge arst_n) begin
    if (!arst_n) begin
      vga_q.cs  <= 1'b1;                    // Syncs are active low
      vga_q.hs  <= 1'b1;
      vga_q.vs  <= 1'b1;
      vga_q.rgb <= '0;
    end else begin
      vga_q.cs  <= chip.cs;
      vga_q.hs  <= chip.hs;
      vga_q.vs  <= chip.vs;
      vga_q.rgb <= sel_rgb;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // OSD overlay
  ////////////////////////////////////////////////////////////////////////////

  assign osd_r_top = osd.pixel ? 2'b11 : 2'b00;
  assign osd_g_top = osd.pixel ? 2'b11 : 2'b00;
  assign osd_b_top = osd.pixel ? 2'b11 : 2'b10; // Blue-tinted background

  always_comb begin
    vga = vga_q;                            // Syncs pass untouched
    if (osd.window) begin
      vga.rgb.r = overlay(vga_q.rgb.r, osd_r_top);
      vga.rgb.g = overlay(vga_q.rgb.g, osd_g_top);
      vga.rgb.b = overlay(vga_q.rgb.b, osd_b_top);
    end
  end

endmodule

`default_nettype wire

// File: rtg_video_top.sv
// Graphics-card video path only; fifo_depth_log2 1..5, single clock CLK_114 throughout
`default_nettype none
`timescale 1ns/1ns

module rtg_video_top #(
  parameter int unsigned fifo_depth_log2 = 3 // Pixel FIFO depth, log2
) (
  input  logic                        CLK_114,
  input  logic                        arst_n,
  input  rtg_video_pkg::chip_video_t  chip,   // Chipset video
  input  rtg_video_pkg::osd_t         osd,
  input  rtg_video_pkg::rtg_cfg_t     cfg,    // Card mode registers
  output rtg_bus_pkg::wb_req_t        wb_req,
  input  rtg_bus_pkg::wb_rsp_t        wb_rsp,
  output rtg_video_pkg::vga_t         vga
);

  import rtg_video_pkg::*;

  pix_ctl_t  ctl;                           // Timing to fetch and output
  hicolour_t head;                          // FIFO head word

  ////////////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////////////

  rtg_fetch #(
    .fifo_depth_log2 (fifo_depth_log2)
  ) i_fetch (
    .CLK_114  (CLK_114),
    .arst_n   (arst_n),
    .cfg_base (cfg.base),
    .ctl      (ctl),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .head     (head)
  );

  rtg_pixel_timing i_timing (
    .CLK_114 (CLK_114),
    .arst_n  (arst_n),
    .chip    (chip),
    .cfg     (cfg),
    .ctl     (ctl)
  );

  rtg_colour_out i_colour (
    .CLK_114 (CLK_114),
    .arst_n  (arst_n),
    .chip    (chip),
    .ctl     (ctl),
    .head    (head),
    .osd     (osd),
    .vga     (vga)
  );

endmodule

`default_nettype wire

// File: rtg_wb_checker.sv
// Bound into rtg_fetch; checks Wishbone classic master rules, failures also counted in fail_cnt
`default_nettype none
`timescale 1ns/1ns

module rtg_wb_checker (
  input logic                 CLK_114,
  input logic                 arst_n,
  input rtg_bus_pkg::wb_req_t wb_req,
  input rtg_bus_pkg::wb_rsp_t wb_rsp
);

  int unsigned fail_cnt = 0;                // Read by the testbench

  ////////////////////////////////////////////////////////////////////////////
  // Master protocol
  ////////////////////////////////////////////////////////////////////////////

  a_stb_in_cyc: assert property (@(posedge CLK_114) disable iff (!arst_n)
    wb_req.stb |-> wb_req.cyc)
  else begin
    fail_cnt++;
    $error("stb high while cyc low");
  end

  // Request frozen until the slave acks
  a_req_hold: assert property (@(posedge CLK_114) disable iff (!arst_n)
    (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr)))
  else begin
    fail_cnt++;
    $error("stb or adr changed before ack");
  end

  a_rst_quiet: assert property (@(posedge CLK_114)
    $rose(arst_n) |-> !wb_req.cyc)
  else begin
    fail_cnt++;
    $error("cyc high right after reset release");
  end

endmodule

`default_nettype wire

// File: tb_rtg_video.sv
// Lines of 64 clocks, 48 active; card rows need vbend >= 1 so the FIFO fills before display
`default_nettype none
`timescale 1ns/1ns

module tb_rtg_video;

  import rtg_video_pkg::*;
  import rtg_bus_pkg::*;

  localparam int line_len   = 64;          // Clocks per line
  localparam int active_len = 48;          // Then hblank to line end
  localparam int vb_lines   = 2;           // Chipset vblank lines per frame
  localparam int n_rows     = 5;

  typedef struct {
    rtg_cfg_t cfg;
    rgb_t     chip_rgb;
    logic     osd_on;                      // OSD window in mid line
    int       lines;                       // Lines after chipset vblank
    logic     hold;                        // Check pixel hold length
    int       ack_min;                     // Extra ack delay
  } row_t;

  logic        CLK_114;
  logic        arst_n;
  chip_video_t chip;
  osd_t        osd;
  rtg_cfg_t    cfg;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  vga_t        vga;

  row_t        rows [n_rows];
  int unsigned rgb_errs = 0;
  int unsigned addr_errs = 0;
  int unsigned sync_errs = 0;
  int unsigned other_errs = 0;
  int unsigned reads = 0;
  int          cycles = 0;
  int          limit = 0;
  // Reference model state
  logic        lvb = 1'b1;                 // Local vblank
  int          lcnt = 0;
  logic        hs_prev = 1'b1;
  logic        cur_card = 1'b0;            // Card colour selected this clock
  logic        have_card;
  rgb_t        last_card;
  int          idx;
  int          run_len;
  logic        hold_on;
  // Memory model state
  int          ack_min = 0;
  logic        busy = 1'b0;
  int          wait_cnt = 0;
  wb_addr_t    exp_adr = '0;               // Unmangled next read
  wb_data_t    rd_dat;

  rtg_video_top #(.fifo_depth_log2(3)) i_dut (
    .CLK_114 (CLK_114),
    .arst_n  (arst_n),
    .chip    (chip),
    .osd     (osd),
    .cfg     (cfg),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .vga     (vga)
  );

  bind rtg_fetch rtg_wb_checker i_wb_checker (
    .CLK_114 (CLK_114),
    .arst_n  (arst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp)
  );

  initial begin
    CLK_114 = 1'b0;
    forever #2 CLK_114 = ~CLK_114;         // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference functions and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Bit 23 flips when bit 22 or bit 21 is set
  function automatic wb_addr_t mangled(input wb_addr_t a);
    wb_addr_t flip;
    flip     = '0;
    flip[23] = a[22] | a[21];
    return a ^ flip;
  endfunction

  function automatic hicolour_t word_at(input line_base_t base, input int i);
    wb_addr_t a;
    a = {base, 4'b0000} + wb_addr_t'(2 * i);
    return hicolour_t'(a[16:1]);           // Memory data rule
  endfunction

  function automatic rgb_t expand_word(input hicolour_t w);
    rgb_t e;
    e.r = {w.r, w.r[4:2]};
    e.g = {w.g, w.g[4:2]};
    e.b = {w.b, w.b[4:2]};
    return e;
  endfunction

  function automatic rgb_t apply_osd(input rgb_t c, input osd_t o);
    rgb_t v;
    v = c;
    if (o.window) begin
      v.r = {(o.pixel ? 2'b11 : 2'b00), c.r[7:2]};
      v.g = {(o.pixel ? 2'b11 : 2'b00), c.g[7:2]};
      v.b = {(o.pixel ? 2'b11 : 2'b10), c.b[7:2]};
    end
    return v;
  endfunction

  task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
      rgb_errs++;
      $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input wb_addr_t got, input wb_addr_t exp);
    if (got !== exp) begin
      addr_errs++;
      $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_sync(input string name, input vga_t got, input vga_t exp);
    if ({got.cs, got.hs, got.vs} !== {exp.cs, exp.hs, exp.vs}) begin
      sync_errs++;
      $display("[ERROR] %s got %h expected %h at %0t", name,
               {got.cs, got.hs, got.vs}, {exp.cs, exp.hs, exp.vs}, $time);
    end
  endtask

  task automatic end_run();
    if (hold_on && run_len != 0 && run_len != int'(cfg.pixel_width) + 1) begin
      other_errs++;
      $display("Pixel held %0d clocks instead of %0d at %0t", run_len,
               int'(cfg.pixel_width) + 1, $time);
    end
    run_len = 0;
  endtask

  // Distinct card colours must follow memory order
  task automatic track_card(input rgb_t got);
    if (!have_card || got !== last_card) begin
      if (have_card) begin
        idx++;
      end
      end_run();
      check_rgb("vga.rgb", got, expand_word(word_at(cfg.base, idx)));
      have_card = 1'b1;
      last_card = got;
    end
    run_len++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, one clock per call
  ////////////////////////////////////////////////////////////////////////////

  task automatic step(input chip_video_t c, input osd_t o, input rtg_cfg_t g);
    vga_t exp_v;
    logic card_q;
    @(posedge CLK_114);
    card_q    = cur_card;                  // Registered on this edge
    exp_v.cs  = chip.cs;
    exp_v.hs  = chip.hs;
    exp_v.vs  = chip.vs;
    exp_v.rgb = chip.rgb;
    if (chip.vblank) begin
      lvb  = 1'b1;
      lcnt = 0;
    end else if (lcnt == int'(cfg.vbend)) begin
      lvb = 1'b0;
    end else if (chip.hs && !hs_prev) begin
      lcnt++;
    end
    hs_prev = chip.hs;
    #1;
    chip     = c;
    osd      = o;
    cfg      = g;
    cur_card = g.ena && !(lvb || c.hblank);
    #2;                                    // Outputs settled
    check_sync("vga.sync", vga, exp_v);
    if (card_q) begin
      track_card(vga.rgb);
    end else begin
      end_run();
      check_rgb("vga.rgb", vga.rgb, apply_osd(exp_v.rgb, o));
    end
  endtask

  task automatic run_frame(input row_t r);
    chip_video_t c;
    osd_t        o;
    logic        vbl;
    have_card = 1'b0;
    idx       = 0;
    run_len   = 0;
    hold_on   = r.hold;
    ack_min   = r.ack_min;
    for (int l = 0; l < r.lines + vb_lines; l++) begin
      for (int x = 0; x < line_len; x++) begin
        vbl      = (l < vb_lines);
        c.vblank = vbl;
        c.hblank = vbl || (x >= active_len);
        c.hs     = !(x >= 50 && x < 56);   // Rises after the active part
        c.vs     = (l != 0);
        c.cs     = c.hs & c.vs;
        c.rgb    = r.chip_rgb ^ rgb_t'({8'h00, 8'(x), 8'(l)});
        o.window = r.osd_on && (x >= 8) && (x < 40);
        o.pixel  = x[1];
        step(c, o, r.cfg);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone memory model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK_114) begin
    #2;
    wb_rsp.ack = 1'b0;
    if (arst_n && wb_req.cyc && wb_req.stb) begin
      if (!busy) begin
        check_addr("wb_req.adr", wb_req.adr, mangled(exp_adr));
        reads++;
        rd_dat   = exp_adr[16:1];
        exp_adr  = exp_adr + 25'd2;
        busy     = 1'b1;
        wait_cnt = ack_min + int'($urandom % 4);
      end
      if (wait_cnt == 0) begin
        wb_rsp.ack = 1'b1;
        wb_rsp.dat = rd_dat;
        busy       = 1'b0;
      end else begin
        wait_cnt--;
      end
    end
    if (!cfg.ena || chip.vblank) begin
      exp_adr = {cfg.base, 4'b0000};       // Frame restart
    end
  end

  always @(posedge CLK_114) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout after %0d cycles", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    int          total;
    int unsigned asrt;
    void'($urandom(32'hc7c8_a362));        // Fixed seed for ack delays
    rows[0] = '{'{1'b0, 21'h000000, 3'd0, 5'd0, 1'b0}, 24'h5a_c3_3c, 1'b1, 4, 1'b0, 0};
    rows[1] = '{'{1'b1, 21'h020000, 3'd5, 5'd2, 1'b0}, 24'h01_40_80, 1'b0, 8, 1'b1, 0};
    rows[2] = '{'{1'b1, 21'h0c1234, 3'd7, 5'd3, 1'b0}, 24'h01_22_44, 1'b0, 8, 1'b1, 0};
    rows[3] = '{'{1'b1, 21'h061000, 3'd6, 5'd1, 1'b1}, 24'h01_10_20, 1'b0, 6, 1'b0, 0};
    rows[4] = '{'{1'b1, 21'h1a0008, 3'd7, 5'd1, 1'b0}, 24'h01_77_11, 1'b0, 6, 1'b0, 3};
    total = 5 + 4;                         // Reset and tail
    for (int i = 0; i < n_rows; i++) begin
      total += (rows[i].lines + vb_lines) * line_len;
    end
    limit  = total + total / 5;
    arst_n = 1'b0;
    chip   = '{hs: 1'b1, vs: 1'b1, cs: 1'b1, hblank: 1'b1, vblank: 1'b1, rgb: '0};
    osd    = '0;
    cfg    = '0;
    wb_rsp = '0;
    repeat (5) @(posedge CLK_114);
    #1 arst_n = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      run_frame(rows[i]);
    end
    repeat (4) step(chip, '0, '0);         // Back to idle
    if (reads == 0) begin
      other_errs++;
      $display("No Wishbone reads were seen");
    end
    asrt = i_dut.i_fetch.i_wb_checker.fail_cnt;
    $display("Errors: rgb %0d, addr %0d, sync %0d, other %0d, assertion %0d",
             rgb_errs, addr_errs, sync_errs, other_errs, asrt);
    if (rgb_errs + addr_errs + sync_errs + other_errs + asrt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtg_bus_pkg.sv
rtg_video_pkg.sv
rtg_fetch.sv
rtg_pixel_timing.sv
rtg_colour_out.sv
rtg_video_top.sv
rtg_wb_checker.sv
tb_rtg_video.sv

// File: Makefile
# Verilator build and run for the graphics-card video path
TOP := tb_rtg_video

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing --assert -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
